//--- src/ctrl_pkg.sv
// shared types, opcodes, FSM states and trap cause codes for the control unit
`default_nettype none

package ctrl_pkg;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b000_0011,
        OP_STORE  = 7'b010_0011,
        OP_RTYPE  = 7'b011_0011,
        OP_ITYPE  = 7'b001_0011,
        OP_BRANCH = 7'b110_0011,
        OP_JAL    = 7'b110_1111,
        OP_JALR   = 7'b110_0111,
        OP_LUI    = 7'b011_0111,
        OP_AUIPC  = 7'b001_0111,
        OP_FENCE  = 7'b000_1111,
        OP_SYSTEM = 7'b111_0011
    } opcode_e;

    typedef enum logic [4:0] {
        S_FETCH, S_DECODE, S_MEM_ADDR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE,
        S_EXEC_R, S_EXEC_I, S_ALU_WB, S_JAL, S_JALR, S_BRANCH, S_LUI, S_AUIPC,
        S_TRAP_0, S_TRAP_1
    } state_e;

    typedef enum logic [3:0] {
        C_LOAD, C_STORE, C_RTYPE, C_ITYPE, C_BRANCH, C_JAL, C_JALR, C_LUI, C_AUIPC,
        C_ECALL, C_EBREAK, C_FENCE, C_ILLEGAL
    } instr_class_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_ARITH, ALU_BRANCH, ALU_LUI, ALU_AUIPC} alu_op_e;
    typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RD1} src_a_e;
    typedef enum logic [1:0] {SRC_B_RD2, SRC_B_IMM, SRC_B_CONST_4} src_b_e;
    typedef enum logic [1:0] {RES_ALUOUT, RES_DATA, RES_ALURESULT} result_src_e;
    typedef enum logic [2:0] {IMM_R, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_e;

    // trap kinds share their numbering with the exception codes
    typedef enum logic [3:0] {
        TK_INSTR_MISALIGN = 4'd0,
        TK_INSTR_FAULT    = 4'd1,
        TK_ILLEGAL        = 4'd2,
        TK_BREAKPOINT     = 4'd3,
        TK_LOAD_MISALIGN  = 4'd4,
        TK_LOAD_FAULT     = 4'd5,
        TK_STORE_MISALIGN = 4'd6,
        TK_STORE_FAULT    = 4'd7,
        TK_ECALL          = 4'd11,
        TK_IRQ            = 4'd15
    } trap_kind_e;

    localparam logic [31:0] CAUSE_INSTR_MISALIGN = 32'd0;
    localparam logic [31:0] CAUSE_INSTR_FAULT    = 32'd1;
    localparam logic [31:0] CAUSE_ILLEGAL        = 32'd2;
    localparam logic [31:0] CAUSE_BREAKPOINT     = 32'd3;
    localparam logic [31:0] CAUSE_LOAD_MISALIGN  = 32'd4;
    localparam logic [31:0] CAUSE_LOAD_FAULT     = 32'd5;
    localparam logic [31:0] CAUSE_STORE_MISALIGN = 32'd6;
    localparam logic [31:0] CAUSE_STORE_FAULT    = 32'd7;
    localparam logic [31:0] CAUSE_ECALL_M        = 32'd11;

    // index i holds the cause of irq line i
    localparam logic [5:0][31:0] CAUSE_IRQ = {
        32'h8000_000B, 32'h8000_0009, 32'h8000_0007,
        32'h8000_0005, 32'h8000_0003, 32'h8000_0001
    };

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- src/ctrl_if.sv
// decode and trap handshake bundles shared by the FSM, decoder and trap unit
`default_nettype none

interface decode_if
    import ctrl_pkg::*;
(
    input logic clk,
    input logic resetn
);
    instr_class_e instr_class;
    imm_src_e     imm_src;
    logic [2:0]   funct3;

    modport decoder (input clk, input resetn, output instr_class, output imm_src, output funct3);
    modport fsm (input instr_class, input imm_src, input funct3);
    modport trap (input instr_class, input funct3);
endinterface

interface trap_if
    import ctrl_pkg::*;
();
    trap_kind_e trap_kind;
    logic       trap_take;
    logic       addr_capture;
    logic       instr_misaligned;
    logic       data_misaligned;
    logic       irq_pending;

    modport fsm (
        output trap_kind, output trap_take, output addr_capture,
        input instr_misaligned, input data_misaligned, input irq_pending
    );
    modport unit (
        input trap_kind, input trap_take, input addr_capture,
        output instr_misaligned, output data_misaligned, output irq_pending
    );
endinterface

`default_nettype wire

//--- src/instr_decoder.sv
// instruction classifier, picks the class and immediate format of the held instruction
`default_nettype none

module instr_decoder
    import ctrl_pkg::*;
(
    input instr_u     instr,
    decode_if.decoder dec
);

    instr_class_e cls;
    logic         sys_base;

    // ecall and ebreak differ only in rs2
    assign sys_base = (instr.r.funct7 == 7'd0) && (instr.r.rs1 == 5'd0)
                   && (instr.r.funct3 == 3'd0) && (instr.r.rd == 5'd0);

    assign dec.funct3      = instr.i.funct3;
    assign dec.instr_class = cls;

    always_comb begin
        cls = C_ILLEGAL;
        case (instr.r.opcode)
            OP_LOAD:   cls = C_LOAD;
            OP_STORE:  cls = C_STORE;
            OP_RTYPE:  cls = C_RTYPE;
            OP_ITYPE:  cls = C_ITYPE;
            OP_BRANCH: cls = C_BRANCH;
            OP_JAL:    cls = C_JAL;
            OP_JALR:   cls = C_JALR;
            OP_LUI:    cls = C_LUI;
            OP_AUIPC:  cls = C_AUIPC;
            // fence.i is not supported
            OP_FENCE: begin
                if (instr.i.funct3 == 3'b000) cls = C_FENCE;
            end
            OP_SYSTEM: begin
                if (sys_base && instr.r.rs2 == 5'd0) cls = C_ECALL;
                else if (sys_base && instr.r.rs2 == 5'd1) cls = C_EBREAK;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (cls)
            C_RTYPE:        dec.imm_src = IMM_R;
            C_STORE:        dec.imm_src = IMM_S;
            C_BRANCH:       dec.imm_src = IMM_B;
            C_LUI, C_AUIPC: dec.imm_src = IMM_U;
            C_JAL:          dec.imm_src = IMM_J;
            default:        dec.imm_src = IMM_I;
        endcase
    end

    a_class_known: assert property (
        @(posedge dec.clk) disable iff (!dec.resetn) !$isunknown(cls)
    );

endmodule

`default_nettype wire

//--- src/main_fsm.sv
// multicycle control FSM, sequences fetch, execute, memory access and trap entry
`default_nettype none

module main_fsm
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        mem_ready,
    input  logic        access_fault,
    input  logic        branch_taken,
    output logic        mem_valid,
    output logic        mem_write,
    output logic        reg_write,
    output logic        pc_update,
    output logic        branch,
    output logic        adr_src,
    output logic        retired,
    output src_a_e      alu_src_a,
    output src_b_e      alu_src_b,
    output alu_op_e     alu_op,
    output result_src_e result_src,
    output logic        instr_load,
    decode_if.fsm       dec,
    trap_if.fsm         trap
);

    state_e     state;
    state_e     state_nxt;
    state_e     done_state;
    trap_kind_e kind;
    trap_kind_e misalign_kind;
    trap_kind_e fault_kind;
    logic       misaligned;
    logic       access_state;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    assign access_state = state inside {S_FETCH, S_MEM_READ, S_MEM_WRITE};

    // per access state: the alignment check, the traps it raises, the state after ready
    always_comb begin
        misaligned    = trap.data_misaligned;
        misalign_kind = TK_LOAD_MISALIGN;
        fault_kind    = TK_LOAD_FAULT;
        done_state    = S_MEM_WB;
        case (state)
            S_FETCH: begin
                misaligned    = trap.instr_misaligned;
                misalign_kind = TK_INSTR_MISALIGN;
                fault_kind    = TK_INSTR_FAULT;
                done_state    = S_DECODE;
            end
            S_MEM_WRITE: begin
                misalign_kind = TK_STORE_MISALIGN;
                fault_kind    = TK_STORE_FAULT;
                done_state    = S_FETCH;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_nxt = S_FETCH;
        kind      = TK_ILLEGAL;
        case (state)
            S_FETCH, S_MEM_READ, S_MEM_WRITE: begin
                if (misaligned) begin
                    state_nxt = S_TRAP_0;
                    kind      = misalign_kind;
                end else if (access_fault) begin
                    state_nxt = S_TRAP_0;
                    kind      = fault_kind;
                end else if (mem_ready) begin
                    state_nxt = done_state;
                end else begin
                    state_nxt = state;
                end
            end
            S_DECODE: begin
                // system traps win over interrupts, interrupts over normal classes
                case (dec.instr_class)
                    C_ILLEGAL: state_nxt = S_TRAP_0;
                    C_ECALL:   state_nxt = S_TRAP_0;
                    C_EBREAK:  state_nxt = S_TRAP_0;
                    default:   state_nxt = trap.irq_pending ? S_TRAP_0 : S_FETCH;
                endcase
                case (dec.instr_class)
                    C_ECALL:  kind = TK_ECALL;
                    C_EBREAK: kind = TK_BREAKPOINT;
                    C_ILLEGAL: kind = TK_ILLEGAL;
                    default:  kind = TK_IRQ;
                endcase
                if (state_nxt != S_TRAP_0) begin
                    case (dec.instr_class)
                        C_LOAD, C_STORE: state_nxt = S_MEM_ADDR;
                        C_RTYPE:         state_nxt = S_EXEC_R;
                        C_ITYPE:         state_nxt = S_EXEC_I;
                        C_BRANCH:        state_nxt = S_BRANCH;
                        C_JAL:           state_nxt = S_JAL;
                        C_JALR:          state_nxt = S_JALR;
                        C_LUI:           state_nxt = S_LUI;
                        C_AUIPC:         state_nxt = S_AUIPC;
                        default:         state_nxt = S_FETCH;
                    endcase
                end
            end
            S_MEM_ADDR: state_nxt = (dec.instr_class == C_LOAD) ? S_MEM_READ : S_MEM_WRITE;
            S_EXEC_R, S_EXEC_I, S_JAL, S_LUI, S_AUIPC: state_nxt = S_ALU_WB;
            S_JALR:   state_nxt = S_JAL;
            S_TRAP_0: state_nxt = S_TRAP_1;
            default:  state_nxt = S_FETCH;
        endcase
    end

    assign trap.trap_kind    = kind;
    assign trap.trap_take    = (state_nxt == S_TRAP_0);
    assign trap.addr_capture = access_state;

    always_comb begin
        mem_valid  = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        pc_update  = 1'b0;
        branch     = 1'b0;
        adr_src    = 1'b0;
        alu_src_a  = SRC_A_PC;
        alu_src_b  = SRC_B_RD2;
        alu_op     = ALU_ADD;
        result_src = RES_ALUOUT;
        if (access_state) mem_valid = !misaligned;
        case (state)
            S_FETCH: begin
                alu_src_b  = SRC_B_CONST_4;
                result_src = RES_ALURESULT;
                pc_update  = instr_load;
            end
            S_DECODE: begin
                alu_src_a = SRC_A_OLD_PC;
                alu_src_b = SRC_B_IMM;
            end
            S_MEM_ADDR, S_JALR: begin
                alu_src_a = SRC_A_RD1;
                alu_src_b = SRC_B_IMM;
            end
            S_MEM_READ: adr_src = 1'b1;
            S_MEM_WRITE: begin
                adr_src   = 1'b1;
                mem_write = 1'b1;
            end
            S_MEM_WB: begin
                result_src = RES_DATA;
                reg_write  = 1'b1;
            end
            S_EXEC_R: begin
                alu_src_a = SRC_A_RD1;
                alu_op    = ALU_ARITH;
            end
            S_EXEC_I: begin
                alu_src_a = SRC_A_RD1;
                alu_src_b = SRC_B_IMM;
                alu_op    = ALU_ARITH;
            end
            S_ALU_WB: reg_write = 1'b1;
            // target already in ALUOut, link address computed alongside
            S_JAL: begin
                alu_src_a = SRC_A_OLD_PC;
                alu_src_b = SRC_B_CONST_4;
                pc_update = 1'b1;
            end
            S_BRANCH: begin
                alu_src_a = SRC_A_RD1;
                alu_op    = ALU_BRANCH;
                branch    = 1'b1;
                mem_valid = branch_taken;
            end
            S_LUI: begin
                alu_src_b = SRC_B_IMM;
                alu_op    = ALU_LUI;
            end
            S_AUIPC: begin
                alu_src_a = SRC_A_OLD_PC;
                alu_src_b = SRC_B_IMM;
                alu_op    = ALU_AUIPC;
            end
            S_TRAP_1: pc_update = 1'b1;
            default: ;
        endcase
    end

    assign instr_load = (state == S_FETCH) && mem_valid && mem_ready && !access_fault;

    assign retired = (state inside {S_ALU_WB, S_MEM_WB, S_BRANCH})
                  || (state == S_MEM_WRITE && mem_valid && mem_ready && !access_fault)
                  || (state == S_DECODE && dec.instr_class == C_FENCE && !trap.irq_pending);

    a_no_write_clash: assert property (
        @(posedge clk) disable iff (!resetn) !(mem_write && reg_write)
    );

    a_trap_no_mem: assert property (
        @(posedge clk) disable iff (!resetn) state inside {S_TRAP_0, S_TRAP_1} |-> !mem_valid
    );

endmodule

`default_nettype wire

//--- src/trap_unit.sv
// alignment checks, fault address capture, interrupt priority and cause/badaddr reporting
`default_nettype none

module trap_unit
    import ctrl_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic [XLEN-1:0] mem_addr,
    input  instr_u          instr,
    input  logic [5:0]      irq,
    output logic            exception_event,
    output logic [XLEN-1:0] cause,
    output logic [XLEN-1:0] badaddr,
    decode_if.trap          dec,
    trap_if.unit            trap
);

    logic [XLEN-1:0] trap_addr;
    logic [XLEN-1:0] irq_cause;
    logic [XLEN-1:0] irq_cause_q;
    trap_kind_e      kind_q;
    logic            size_misaligned;

    assign trap.instr_misaligned = mem_addr[1:0] != 2'b00;
    assign trap.irq_pending      = |irq;

    // funct3[1:0] gives the access size: byte, half, word
    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   size_misaligned = 1'b0;
            2'b01:   size_misaligned = mem_addr[0];
            default: size_misaligned = mem_addr[1:0] != 2'b00;
        endcase
    end

    assign trap.data_misaligned = (dec.instr_class inside {C_LOAD, C_STORE}) && size_misaligned;

    // lowest index wins
    always_comb begin
        irq_cause = '0;
        for (int i = 5; i >= 0; i--) begin
            if (irq[i]) irq_cause = XLEN'(CAUSE_IRQ[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exception_event <= 1'b0;
        end else begin
            exception_event <= trap.trap_take;
        end
    end

    always_ff @(posedge clk) begin
        if (trap.addr_capture) trap_addr <= mem_addr;
        if (trap.trap_take) begin
            kind_q      <= trap.trap_kind;
            irq_cause_q <= irq_cause;
        end
    end

    always_comb begin
        case (kind_q)
            TK_INSTR_MISALIGN: cause = XLEN'(CAUSE_INSTR_MISALIGN);
            TK_INSTR_FAULT:    cause = XLEN'(CAUSE_INSTR_FAULT);
            TK_ILLEGAL:        cause = XLEN'(CAUSE_ILLEGAL);
            TK_BREAKPOINT:     cause = XLEN'(CAUSE_BREAKPOINT);
            TK_LOAD_MISALIGN:  cause = XLEN'(CAUSE_LOAD_MISALIGN);
            TK_LOAD_FAULT:     cause = XLEN'(CAUSE_LOAD_FAULT);
            TK_STORE_MISALIGN: cause = XLEN'(CAUSE_STORE_MISALIGN);
            TK_STORE_FAULT:    cause = XLEN'(CAUSE_STORE_FAULT);
            TK_ECALL:          cause = XLEN'(CAUSE_ECALL_M);
            TK_IRQ:            cause = irq_cause_q;
            default:           cause = '0;
        endcase
        badaddr = '0;
        if (kind_q == TK_ILLEGAL) badaddr = XLEN'(instr.r.opcode);
        else if (kind_q inside {TK_INSTR_MISALIGN, TK_INSTR_FAULT, TK_LOAD_MISALIGN,
                                TK_LOAD_FAULT, TK_STORE_MISALIGN, TK_STORE_FAULT}) begin
            badaddr = trap_addr;
        end
    end

endmodule

`default_nettype wire

//--- src/retire_counter.sv
// wrapping count of retired instructions, one step per retire pulse
`default_nettype none

module retire_counter #(
    parameter int RETIRE_W = 16
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                retired,
    output logic [RETIRE_W-1:0] retire_count
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            retire_count <= '0;
        end else if (retired) begin
            retire_count <= retire_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/cpu_ctrl_top.sv
// control unit top level, holds the instruction register and joins decoder, FSM and traps
`default_nettype none

module cpu_ctrl_top
    import ctrl_pkg::*;
#(
    parameter int XLEN     = 32,
    parameter int RETIRE_W = 16
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic [31:0]         instr_word,
    input  logic                mem_ready,
    input  logic [XLEN-1:0]     mem_addr,
    input  logic                access_fault,
    input  logic                branch_taken,
    input  logic [5:0]          irq,
    output logic                mem_valid,
    output logic                mem_write,
    output logic                reg_write,
    output logic                pc_update,
    output logic                branch,
    output logic                adr_src,
    output logic                retired,
    output src_a_e              alu_src_a,
    output src_b_e              alu_src_b,
    output alu_op_e             alu_op,
    output result_src_e         result_src,
    output logic                exception_event,
    output logic [XLEN-1:0]     cause,
    output logic [XLEN-1:0]     badaddr,
    output logic [RETIRE_W-1:0] retire_count
);

    instr_u instr_q;
    logic   instr_load;

    decode_if u_decode_if (.clk(clk), .resetn(resetn));
    trap_if   u_trap_if ();

    // loaded on the fetch edge, held until the next fetch completes
    always_ff @(posedge clk) begin
        if (instr_load) instr_q <= instr_word;
    end

    instr_decoder u_instr_decoder (
        .instr (instr_q),
        .dec   (u_decode_if.decoder)
    );

    main_fsm u_main_fsm (
        .clk          (clk),
        .resetn       (resetn),
        .mem_ready    (mem_ready),
        .access_fault (access_fault),
        .branch_taken (branch_taken),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .reg_write    (reg_write),
        .pc_update    (pc_update),
        .branch       (branch),
        .adr_src      (adr_src),
        .retired      (retired),
        .alu_src_a    (alu_src_a),
        .alu_src_b    (alu_src_b),
        .alu_op       (alu_op),
        .result_src   (result_src),
        .instr_load   (instr_load),
        .dec          (u_decode_if.fsm),
        .trap         (u_trap_if.fsm)
    );

    trap_unit #(.XLEN(XLEN)) u_trap_unit (
        .clk             (clk),
        .resetn          (resetn),
        .mem_addr        (mem_addr),
        .instr           (instr_q),
        .irq             (irq),
        .exception_event (exception_event),
        .cause           (cause),
        .badaddr         (badaddr),
        .dec             (u_decode_if.trap),
        .trap            (u_trap_if.unit)
    );

    retire_counter #(.RETIRE_W(RETIRE_W)) u_retire_counter (
        .clk          (clk),
        .resetn       (resetn),
        .retired      (retired),
        .retire_count (retire_count)
    );

endmodule

`default_nettype wire

//--- testbench/tb_ctrl_model.svh
// expected outcome of one instruction, included into the control unit testbench
`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

typedef struct {
    bit          wb;
    bit          data_wb;
    bit          mem_wr;
    bit          branch_pulse;
    bit          trap;
    bit          retire;
    int          xfers;
    int          pc_updates;
    logic [31:0] cause;
    logic [31:0] badaddr;
} expect_t;

function automatic expect_t model_expect(input logic [31:0] word, input logic [31:0] fetch_addr,
                                         input logic [31:0] data_addr, input bit fetch_fault,
                                         input bit data_fault, input logic [5:0] irq_lines);
    expect_t    e;
    logic [6:0] op;
    logic [2:0] f3;
    bit         misal;
    e = '{default: 0};
    op = word[6:0];
    f3 = word[14:12];
    misal = (f3[1:0] == 2'b01 && data_addr[0]) || (f3[1:0] == 2'b10 && data_addr[1:0] != 2'b00);
    e.trap = 1'b1;
    e.xfers = 1;
    e.pc_updates = 2;
    if (fetch_addr[1:0] != 2'b00) begin
        e.cause = 32'd0;
        e.badaddr = fetch_addr;
        e.xfers = 0;
        e.pc_updates = 1;
    end else if (fetch_fault) begin
        e.cause = 32'd1;
        e.badaddr = fetch_addr;
        e.xfers = 0;
        e.pc_updates = 1;
    end else if (!(op inside {7'h03, 7'h23, 7'h33, 7'h13, 7'h63, 7'h6f, 7'h67, 7'h37, 7'h17,
                              7'h0f, 7'h73})
                 || (op == 7'h0f && f3 != 3'd0)
                 || (op == 7'h73 && word != 32'h0000_0073 && word != 32'h0010_0073)) begin
        e.cause = 32'd2;
        e.badaddr = {25'd0, op};
    end else if (word == 32'h0000_0073) begin
        e.cause = 32'd11;
    end else if (word == 32'h0010_0073) begin
        e.cause = 32'd3;
    end else if (irq_lines != 6'd0) begin
        // lowest line wins
        for (int i = 5; i >= 0; i--) begin
            if (irq_lines[i]) e.cause = 32'h8000_0000 | 32'(2 * i + 1);
        end
    end else if ((op == 7'h03 || op == 7'h23) && misal) begin
        e.cause = (op == 7'h03) ? 32'd4 : 32'd6;
        e.badaddr = data_addr;
        // a store raises mem_write in MEM_WRITE before its address is judged
        e.mem_wr = (op == 7'h23);
    end else if ((op == 7'h03 || op == 7'h23) && data_fault) begin
        e.cause = (op == 7'h03) ? 32'd5 : 32'd7;
        e.badaddr = data_addr;
        e.mem_wr = (op == 7'h23);
    end else begin
        e.trap = 1'b0;
        e.retire = 1'b1;
        e.wb = !(op inside {7'h23, 7'h63, 7'h0f});
        e.data_wb = (op == 7'h03);
        e.mem_wr = (op == 7'h23);
        e.branch_pulse = (op == 7'h63);
        e.xfers = (op == 7'h03 || op == 7'h23) ? 2 : 1;
        e.pc_updates = (op == 7'h6f || op == 7'h67) ? 2 : 1;
    end
    return e;
endfunction

`endif

//--- testbench/tb_cpu_ctrl.sv
// testbench for the control unit, runs instruction sequences against a reference model
`default_nettype none

module tb_cpu_ctrl
    import ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    `include "tb_ctrl_model.svh"

    localparam int NUM_INSTR = 31;

    logic        clk;
    logic        resetn;
    logic [31:0] instr_word;
    logic        mem_ready;
    logic [31:0] mem_addr;
    logic        access_fault;
    logic        branch_taken;
    logic [5:0]  irq;
    logic        mem_valid;
    logic        mem_write;
    logic        reg_write;
    logic        pc_update;
    logic        branch;
    logic        adr_src;
    logic        retired;
    src_a_e      alu_src_a;
    src_b_e      alu_src_b;
    alu_op_e     alu_op;
    result_src_e result_src;
    logic        exception_event;
    logic [31:0] cause;
    logic [31:0] badaddr;
    logic [15:0] retire_count;

    int          errors;
    int          tests;
    int          ready_wait;
    logic [31:0] pc;

    cpu_ctrl_top #(.XLEN(32), .RETIRE_W(16)) u_cpu_ctrl_top (
        .clk             (clk),
        .resetn          (resetn),
        .instr_word      (instr_word),
        .mem_ready       (mem_ready),
        .mem_addr        (mem_addr),
        .access_fault    (access_fault),
        .branch_taken    (branch_taken),
        .irq             (irq),
        .mem_valid       (mem_valid),
        .mem_write       (mem_write),
        .reg_write       (reg_write),
        .pc_update       (pc_update),
        .branch          (branch),
        .adr_src         (adr_src),
        .retired         (retired),
        .alu_src_a       (alu_src_a),
        .alu_src_b       (alu_src_b),
        .alu_op          (alu_op),
        .result_src      (result_src),
        .exception_event (exception_event),
        .cause           (cause),
        .badaddr         (badaddr),
        .retire_count    (retire_count)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // memory side, ready comes after a random wait while the FSM asks
    task automatic drive_inputs(input logic [31:0] word, input logic [31:0] fetch_addr,
                                input logic [31:0] data_addr, input bit fetch_fault,
                                input bit data_fault, input logic [5:0] irq_lines);
        instr_word = word;
        mem_addr = adr_src ? data_addr : fetch_addr;
        access_fault = adr_src ? data_fault : fetch_fault;
        irq = irq_lines;
        branch_taken = 1'b0;
        if (ready_wait == 0) begin
            mem_ready = 1'b1;
            ready_wait = int'($urandom % 4);
        end else begin
            mem_ready = 1'b0;
            ready_wait--;
        end
    endtask

    task automatic run_instr(input string name, input logic [31:0] word,
                             input logic [31:0] data_addr, input bit fetch_fault,
                             input bit data_fault, input logic [5:0] irq_lines, input bit skew);
        expect_t     exp;
        logic [31:0] fetch_addr;
        logic [15:0] start_count;
        logic [31:0] got_cause;
        logic [31:0] got_bad;
        int          errors_before;
        int          k;
        int          wb_count;
        int          wb_cycle;
        int          br_count;
        int          pc_count;
        int          xfer_count;
        bit          wb_data;
        bit          mw_seen;
        bit          mw_gap;
        bit          mw_at_done;
        bit          trap_seen;
        bit          done;
        fetch_addr = pc + (skew ? 32'd2 : 32'd0);
        pc += 32'd4;
        tests++;
        exp = model_expect(word, fetch_addr, data_addr, fetch_fault, data_fault, irq_lines);
        start_count = retire_count;
        errors_before = errors;
        k = 0;
        wb_count = 0;
        wb_cycle = 0;
        br_count = 0;
        pc_count = 0;
        xfer_count = 0;
        wb_data = 0;
        mw_seen = 0;
        mw_gap = 0;
        mw_at_done = 0;
        trap_seen = 0;
        done = 0;
        got_cause = '0;
        got_bad = '0;
        while (!done) begin
            @(negedge clk);
            drive_inputs(word, fetch_addr, data_addr, fetch_fault, data_fault, irq_lines);
            #1;
            // DECODE is the only state that adds the immediate to the old pc
            if (alu_src_a == SRC_A_OLD_PC && alu_src_b == SRC_B_IMM && alu_op == ALU_ADD) k = 1;
            else if (k > 0) k++;
            if (reg_write) begin
                wb_count++;
                wb_cycle = k;
                wb_data = (result_src == RES_DATA);
            end
            if (exception_event) begin
                trap_seen = 1;
                got_cause = cause;
                got_bad = badaddr;
            end
            if (mem_write) mw_seen = 1;
            else if (mw_seen && !trap_seen) mw_gap = 1;
            if (branch) br_count++;
            if (pc_update) pc_count++;
            if (mem_valid && mem_ready && !access_fault) xfer_count++;
            if (retired) begin
                done = 1;
                mw_at_done = mem_write && mem_ready;
            end else if (trap_seen && pc_update) begin
                done = 1;
            end
        end
        @(posedge clk);
        #1;
        check_value("reg_write pulses", wb_count, exp.wb);
        check_value("mem_write", mw_seen, exp.mem_wr);
        check_value("mem_write gap", mw_gap, 0);
        check_value("branch pulses", br_count, exp.branch_pulse);
        check_value("pc_update pulses", pc_count, exp.pc_updates);
        check_value("mem_valid transfers", xfer_count, exp.xfers);
        check_value("exception_event", trap_seen, exp.trap);
        check_value("retire_count step", 16'(retire_count - start_count), exp.retire);
        if (exp.trap) begin
            check_value("cause", got_cause, exp.cause);
            check_value("badaddr", got_bad, exp.badaddr);
        end
        if (exp.data_wb) check_value("result_src data", wb_data, 1);
        if (exp.mem_wr && exp.retire) check_value("mem_write at ready", mw_at_done, 1);
        if (word[6:0] == 7'h33 && !exp.trap) check_value("reg_write cycle", wb_cycle, 3);
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "error");
    endtask

    initial begin
        repeat (5 + 40 * NUM_INSTR) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(70635));
        clk = 1'b0;
        resetn = 1'b0;
        instr_word = '0;
        mem_ready = 1'b0;
        mem_addr = '0;
        access_fault = 1'b0;
        branch_taken = 1'b0;
        irq = '0;
        errors = 0;
        tests = 0;
        ready_wait = 0;
        pc = 32'h0000_1000;
        repeat (5) @(negedge clk);
        resetn = 1'b1;

        // plain execution classes
        run_instr("add", 32'h0020_81b3, 32'h0, 0, 0, 6'd0, 0);
        run_instr("addi", 32'h0050_8093, 32'h0, 0, 0, 6'd0, 0);
        run_instr("lui", 32'h1234_50b7, 32'h0, 0, 0, 6'd0, 0);
        run_instr("auipc", 32'h0000_1097, 32'h0, 0, 0, 6'd0, 0);
        run_instr("jal", 32'h0080_00ef, 32'h0, 0, 0, 6'd0, 0);
        run_instr("jalr", 32'h0000_80e7, 32'h0, 0, 0, 6'd0, 0);
        run_instr("beq", 32'h0020_8463, 32'h0, 0, 0, 6'd0, 0);

        run_instr("lw", 32'h0000_a183, 32'h0000_0100, 0, 0, 6'd0, 0);
        run_instr("lh", 32'h0000_9183, 32'h0000_0102, 0, 0, 6'd0, 0);
        run_instr("lb", 32'h0000_8183, 32'h0000_0103, 0, 0, 6'd0, 0);
        run_instr("sw", 32'h0030_a023, 32'h0000_0200, 0, 0, 6'd0, 0);
        run_instr("sh", 32'h0030_9023, 32'h0000_0206, 0, 0, 6'd0, 0);
        for (int i = 0; i < 4; i++) begin
            run_instr("lw random", 32'h0000_a183, {20'd0, 10'($urandom), 2'b00}, 0, 0, 6'd0, 0);
        end

        // misaligned accesses
        run_instr("lh misaligned", 32'h0000_9183, 32'h0000_0101, 0, 0, 6'd0, 0);
        run_instr("lw misaligned", 32'h0000_a183, 32'h0000_0102, 0, 0, 6'd0, 0);
        run_instr("sw misaligned", 32'h0030_a023, 32'h0000_0201, 0, 0, 6'd0, 0);
        run_instr("sh misaligned", 32'h0030_9023, 32'h0000_0203, 0, 0, 6'd0, 0);
        run_instr("fetch misaligned", 32'h0020_81b3, 32'h0, 0, 0, 6'd0, 1);

        run_instr("fetch fault", 32'h0020_81b3, 32'h0, 1, 0, 6'd0, 0);
        run_instr("load fault", 32'h0000_a183, 32'h0000_0300, 0, 1, 6'd0, 0);
        run_instr("store fault", 32'h0030_a023, 32'h0000_0304, 0, 1, 6'd0, 0);

        run_instr("illegal 7f", 32'h0000_007f, 32'h0, 0, 0, 6'd0, 0);
        run_instr("illegal 0b", 32'h0000_000b, 32'h0, 0, 0, 6'd0, 0);
        run_instr("ecall", 32'h0000_0073, 32'h0, 0, 0, 6'd0, 0);
        run_instr("ebreak", 32'h0010_0073, 32'h0, 0, 0, 6'd0, 0);

        run_instr("irq 2,3,5", 32'h0020_81b3, 32'h0, 0, 0, 6'b101100, 0);
        run_instr("irq 5", 32'h0050_8093, 32'h0, 0, 0, 6'b100000, 0);
        run_instr("fence", 32'h0000_000f, 32'h0, 0, 0, 6'd0, 0);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/ctrl_pkg.sv
src/ctrl_if.sv
src/instr_decoder.sv
src/main_fsm.sv
src/trap_unit.sv
src/retire_counter.sv
src/cpu_ctrl_top.sv
+incdir+testbench
testbench/tb_cpu_ctrl.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_ctrl \
		-f src.f -o sim
	./obj_dir/sim | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
